/* Makefile */
# Verilator build and run of the MEM stage testbench

VERILATOR ?= verilator
TOP       ?= mem_stage_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* list.f */
verilog/cpu_pkg.sv
verilog/mem_ctrl.sv
verilog/data_ram.sv
verilog/mem_reg.sv
verilog/mem_stage.sv
tb/tb_clk_gen.sv
tb/mem_stage_props.sv
tb/mem_stage_tb.sv

/* tb/mem_stage_props.sv */
`timescale 1ns/1ns

module mem_stage_props (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            stall,
    input logic                            flush,
    input logic                            miss_align,  // internal to mem_stage
    input logic                            mem_en,
    input logic                            mem_gpr_we,
    input logic                            out_rdy,
    input logic [cpu_pkg::word_data_w-1:0] mem_out
);

    // a completed load always writes back a valid slot
    rdy_has_write: assert property (@(posedge clk) disable iff (!rst_n)
        out_rdy |-> (mem_en && mem_gpr_we))
        else $error("out_rdy high without mem_en and mem_gpr_we");

    // held register
    stall_holds_out: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(mem_out))
        else $error("mem_out changed across a stall");

    // misaligned access retires without a register write
    misalign_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        (miss_align && !stall && !flush) |=> !mem_gpr_we)
        else $error("mem_gpr_we set after a misaligned access");

    // pulse is dropped on a stalled edge
    stall_kills_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> !out_rdy)
        else $error("out_rdy high after a stall");

endmodule

/* tb/mem_stage_tb.sv */
`timescale 1ns/1ns

module mem_stage_tb;

    import cpu_pkg::*;

    // test lengths in cycles
    localparam int len_store_load = 56;
    localparam int len_pass       = 30;
    localparam int len_misalign   = 24;
    localparam int len_stall      = 24;
    localparam int len_random     = 400;
    localparam int total_cycles   = 8 + 2 + len_store_load + len_pass + len_misalign
                                    + len_stall + len_random;
    localparam int watchdog_ns    = 2 * total_cycles * 20;

    logic                   clk;
    logic                   rst_n;
    logic                   ex_en;
    mem_op_e                ex_mem_op;
    logic [word_data_w-1:0] ex_alu_out;
    logic [word_data_w-1:0] ex_store_data;
    logic [reg_addr_w-1:0]  ex_dst_addr;
    logic                   ex_gpr_we;
    logic                   stall;
    logic                   flush;
    logic                   mem_en;
    logic [reg_addr_w-1:0]  mem_dst_addr;
    logic                   mem_gpr_we;
    logic [word_data_w-1:0] mem_out;
    logic                   out_rdy;

    // model state
    logic [word_data_w-1:0] ram_model [dmem_depth];
    logic                   exp_en;
    logic [reg_addr_w-1:0]  exp_dst;
    logic                   exp_we;
    logic [word_data_w-1:0] exp_out;
    logic                   exp_rdy;

    int seed;
    int checks;
    int errors;
    int err_start;

    tb_clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mem_stage UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .ex_en         (ex_en),
        .ex_mem_op     (ex_mem_op),
        .ex_alu_out    (ex_alu_out),
        .ex_store_data (ex_store_data),
        .ex_dst_addr   (ex_dst_addr),
        .ex_gpr_we     (ex_gpr_we),
        .stall         (stall),
        .flush         (flush),
        .mem_en        (mem_en),
        .mem_dst_addr  (mem_dst_addr),
        .mem_gpr_we    (mem_gpr_we),
        .mem_out       (mem_out),
        .out_rdy       (out_rdy)
    );

    bind mem_stage mem_stage_props u_props (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .flush      (flush),
        .miss_align (miss_align),
        .mem_en     (mem_en),
        .mem_gpr_we (mem_gpr_we),
        .out_rdy    (out_rdy),
        .mem_out    (mem_out)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h at %0t ns", name, got, exp, $time);
        end
    endtask

    task automatic compare_outputs();
        check_value("mem_en", 32'(mem_en), 32'(exp_en));
        check_value("mem_dst_addr", 32'(mem_dst_addr), 32'(exp_dst));
        check_value("mem_gpr_we", 32'(mem_gpr_we), 32'(exp_we));
        check_value("mem_out", mem_out, exp_out);
        check_value("out_rdy", 32'(out_rdy), 32'(exp_rdy));
    endtask

    // 16 word window, upper bits random so the index wraps
    function automatic logic [31:0] make_addr(input logic [31:0] r, input logic misalign);
        logic [31:0] a;
        a = r & 32'hffff_fc3c;
        if (misalign) begin
            a[1:0] = (r[7:6] == 2'b00) ? 2'b10 : r[7:6];
        end
        return a;
    endfunction

    // drive one slot at edge+2, step the model, check after the next edge
    task automatic run_cycle(input logic en, input mem_op_e op, input logic [31:0] alu,
                             input logic [31:0] sdata, input logic [4:0] dst,
                             input logic gwe, input logic stl, input logic fls);
        logic [7:0]  idx;
        logic        aligned;
        logic        access;
        logic [31:0] result;
        ex_en         = en;
        ex_mem_op     = op;
        ex_alu_out    = alu;
        ex_store_data = sdata;
        ex_dst_addr   = dst;
        ex_gpr_we     = gwe;
        stall         = stl;
        flush         = fls;
        idx     = alu[9:2];  // bits above 9 ignored
        aligned = (alu[1:0] == 2'b00);
        access  = en && (op == mem_op_ldw || op == mem_op_stw);
        if (op == mem_op_ldw) begin
            result = ram_model[idx];  // read sees older stores only
        end else if (op == mem_op_stw) begin
            result = 32'h0;
        end else begin
            result = alu;
        end
        exp_rdy = 1'b0;  // pulse
        if (!stl) begin
            if (fls) begin
                exp_en  = 1'b0;
                exp_dst = '0;
                exp_we  = 1'b0;
                exp_out = '0;
            end else if (access && !aligned) begin
                exp_en  = en;  // valid but silent
                exp_dst = '0;
                exp_we  = 1'b0;
                exp_out = '0;
            end else begin
                exp_en  = en;
                exp_dst = dst;
                exp_we  = gwe;
                exp_out = result;
                exp_rdy = en && (op == mem_op_ldw);
            end
        end
        if (en && op == mem_op_stw && aligned && !stl && !fls) begin
            ram_model[idx] = sdata;
        end
        @(posedge clk);
        #2;
        compare_outputs();
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s done, %0d mismatches", num, name, errors - err_start);
        err_start = errors;
    endtask

    // watchdog
    initial begin
        #watchdog_ns;
        $display("timeout: run did not complete within %0d ns", watchdog_ns);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] a;
        logic [31:0] d;
        mem_op_e     op;
        seed          = 32'hd703_d36a;
        checks        = 0;
        errors        = 0;
        err_start     = 0;
        ex_en         = 1'b0;
        ex_mem_op     = mem_op_nop;
        ex_alu_out    = '0;
        ex_store_data = '0;
        ex_dst_addr   = '0;
        ex_gpr_we     = 1'b0;
        stall         = 1'b0;
        flush         = 1'b0;
        exp_en        = 1'b0;
        exp_dst       = '0;
        exp_we        = 1'b0;
        exp_out       = '0;
        exp_rdy       = 1'b0;

        // 1: outputs at reset release, then after one idle capture
        wait (rst_n);
        compare_outputs();  // reset values, no capture edge yet
        @(posedge clk);
        #2;
        compare_outputs();
        end_test(1, "reset");

        // 2: fill the window, then read it back
        for (int i = 0; i < 16; i++) begin
            r = $random(seed);
            d = $random(seed);
            a = (r & 32'hffff_fc00) | {26'b0, i[3:0], 2'b00};
            run_cycle(1'b1, mem_op_stw, a, d, r[14:10], r[15], 1'b0, 1'b0);
        end
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            run_cycle(1'b1, mem_op_ldw, make_addr(r, 1'b0), 32'h0, r[14:10], 1'b1,
                      1'b0, 1'b0);
        end
        end_test(2, "store then load");

        // 3: no-op passthrough, store result, load back
        for (int i = 0; i < 10; i++) begin
            r  = $random(seed);
            r2 = $random(seed);
            d  = $random(seed);
            run_cycle(1'b1, mem_op_nop, r2, d, r[4:0], r[5], 1'b0, 1'b0);
            a = make_addr(r2, 1'b0);
            run_cycle(1'b1, mem_op_stw, a, d, r[10:6], r[11], 1'b0, 1'b0);
            run_cycle(1'b1, mem_op_ldw, a, 32'h0, r[16:12], 1'b1, 1'b0, 1'b0);
        end
        end_test(3, "nop and store");

        // 4: misaligned load and store, memory untouched
        for (int i = 0; i < 8; i++) begin
            r = $random(seed);
            d = $random(seed);
            a = make_addr(r, 1'b1);
            run_cycle(1'b1, mem_op_ldw, a, 32'h0, r[14:10], 1'b1, 1'b0, 1'b0);
            run_cycle(1'b1, mem_op_stw, a, d, r[19:15], 1'b1, 1'b0, 1'b0);
            run_cycle(1'b1, mem_op_ldw, a & ~32'h3, 32'h0, r[24:20], 1'b1, 1'b0, 1'b0);
        end
        end_test(4, "misaligned");

        // 5: stall holds and blocks writes, flush clears
        for (int i = 0; i < 4; i++) begin
            r = $random(seed);
            d = $random(seed);
            a = make_addr(r, 1'b0);
            run_cycle(1'b1, mem_op_ldw, a, 32'h0, r[14:10], 1'b1, 1'b0, 1'b0);
            run_cycle(1'b1, mem_op_stw, a, d, r[19:15], 1'b1, 1'b1, 1'b0);
            run_cycle(1'b1, mem_op_stw, a, d, r[19:15], 1'b1, 1'b1, 1'b1);  // stall wins
            run_cycle(1'b1, mem_op_ldw, a, 32'h0, r[24:20], 1'b1, 1'b0, 1'b0);
            run_cycle(1'b1, mem_op_stw, a, d, r[19:15], 1'b1, 1'b0, 1'b1);
            run_cycle(1'b1, mem_op_ldw, a, 32'h0, r[29:25], 1'b1, 1'b0, 1'b0);
        end
        end_test(5, "stall and flush");

        // 6: random mix
        for (int i = 0; i < len_random; i++) begin
            r  = $random(seed);
            r2 = $random(seed);
            d  = $random(seed);
            case (r[3:2])
                2'd1:    op = mem_op_ldw;
                2'd2:    op = mem_op_stw;
                default: op = mem_op_nop;
            endcase
            a = (op == mem_op_nop) ? r2 : make_addr(r2, r[6:4] == 3'b000);
            run_cycle(r[1:0] != 2'b00, op, a, d, r[11:7],
                      (op == mem_op_ldw) ? 1'b1 : r[12],   // loads always write back
                      r[15:13] == 3'b000, r[19:16] == 4'b0000);
        end
        end_test(6, "random mix");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held for 8 cycles, released just after an edge
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #2 rst_n = 1'b1;
    end

endmodule

/* verilog/cpu_pkg.sv */
package cpu_pkg;

    // datapath widths
    localparam int word_data_w = 32;  // one data word
    localparam int reg_addr_w  = 5;   // 32 general purpose registers

    // data memory geometry
    localparam int dmem_depth  = 256;  // words in the data ram
    localparam int dmem_addr_w = 8;    // word index taken from byte address bits 9..2

    // memory operation carried down the pipe from decode
    typedef enum logic [1:0] {
        mem_op_nop = 2'b00,  // no access, alu value passes through
        mem_op_ldw = 2'b01,  // word load
        mem_op_stw = 2'b10   // word store
    } mem_op_e;

endpackage

/* verilog/data_ram.sv */
`timescale 1ns/1ns

module data_ram (
    input  logic                            clk,
    input  logic [cpu_pkg::dmem_addr_w-1:0] addr,   // word index
    input  logic [cpu_pkg::word_data_w-1:0] wdata,
    input  logic                            we,     // write at rising edge
    output logic [cpu_pkg::word_data_w-1:0] rdata   // async read
);

    import cpu_pkg::*;

    logic [word_data_w-1:0] mem [dmem_depth];  // storage only

    // clocked write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // read is combinational so a load sees earlier stores in the same cycle
    assign rdata = mem[addr];

endmodule

/* verilog/mem_ctrl.sv */
`timescale 1ns/1ns

module mem_ctrl (
    // ex/mem pipeline fields
    input  logic                          ex_en,          // slot holds a valid instruction
    input  cpu_pkg::mem_op_e              ex_mem_op,      // memory operation
    input  logic [cpu_pkg::word_data_w-1:0] ex_alu_out,   // byte address or alu result
    input  logic [cpu_pkg::word_data_w-1:0] ex_store_data,
    // pipeline control
    input  logic                          stall,
    input  logic                          flush,
    // data ram side
    input  logic [cpu_pkg::word_data_w-1:0] ram_rdata,    // combinational read data
    output logic [cpu_pkg::dmem_addr_w-1:0] ram_addr,     // word index
    output logic [cpu_pkg::word_data_w-1:0] ram_wdata,
    output logic                          ram_we,
    // towards mem/wb register
    output logic [cpu_pkg::word_data_w-1:0] mem_result,   // stage result
    output logic                          miss_align,
    output logic                          load_rdy        // valid aligned load
);

    import cpu_pkg::*;

    logic is_ldw;     // op decode
    logic is_stw;
    logic is_access;  // valid load or store
    logic addr_ok;    // byte offset is zero

    // decode
    assign is_ldw    = (ex_mem_op == mem_op_ldw);
    assign is_stw    = (ex_mem_op == mem_op_stw);
    assign is_access = ex_en & (is_ldw | is_stw);
    assign addr_ok   = (ex_alu_out[1:0] == 2'b00);

    // alignment check only matters for real accesses
    assign miss_align = is_access & ~addr_ok;
    assign load_rdy   = ex_en & is_ldw & addr_ok;

    // ram drive
    assign ram_addr  = ex_alu_out[dmem_addr_w+1:2];  // upper bits dropped, address wraps
    assign ram_wdata = ex_store_data;
    // write only when the slot really retires this cycle
    assign ram_we    = ex_en & is_stw & addr_ok & ~stall & ~flush;

    // result select
    always_comb begin
        unique case (ex_mem_op)
            mem_op_nop: mem_result = ex_alu_out;  // pass alu value
            mem_op_ldw: mem_result = ram_rdata;   // loaded word
            mem_op_stw: mem_result = '0;          // store gives nothing back
            default:    mem_result = '0;          // unused encoding
        endcase
    end

endmodule

/* verilog/mem_reg.sv */
`timescale 1ns/1ns

module mem_reg (
    input  logic                            clk,
    input  logic                            rst_n,         // async, active low
    // stage result
    input  logic [cpu_pkg::word_data_w-1:0] out,           // from mem_ctrl
    input  logic                            miss_align,
    // pipeline control
    input  logic                            stall,
    input  logic                            flush,
    // ex/mem fields
    input  logic                            ex_en,
    input  logic [cpu_pkg::reg_addr_w-1:0]  ex_dst_addr,
    input  logic                            ex_gpr_we,
    input  logic                            load_rdy,      // aligned valid load
    // mem/wb register
    output logic                            mem_en,
    output logic [cpu_pkg::reg_addr_w-1:0]  mem_dst_addr,
    output logic                            mem_gpr_we,
    output logic                            out_rdy,       // one cycle pulse
    output logic [cpu_pkg::word_data_w-1:0] mem_out
);

    // priority is stall, flush, misalign, capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_en       <= 1'b0;
            mem_dst_addr <= '0;
            mem_gpr_we   <= 1'b0;
            out_rdy      <= 1'b0;
            mem_out      <= '0;
        end else begin
            out_rdy <= 1'b0;  // pulse by default
            if (!stall) begin
                if (flush) begin
                    // bubble
                    mem_en       <= 1'b0;
                    mem_dst_addr <= '0;
                    mem_gpr_we   <= 1'b0;
                    mem_out      <= '0;
                end else if (miss_align) begin
                    // slot stays valid but writes nothing back
                    mem_en       <= ex_en;
                    mem_dst_addr <= '0;
                    mem_gpr_we   <= 1'b0;
                    mem_out      <= '0;
                end else begin
                    mem_en       <= ex_en;
                    mem_dst_addr <= ex_dst_addr;
                    mem_gpr_we   <= ex_gpr_we;
                    mem_out      <= out;
                    out_rdy      <= load_rdy;  // load done next cycle
                end
            end
            // stall holds everything but out_rdy
        end
    end

endmodule

/* verilog/mem_stage.sv */
`timescale 1ns/1ns

module mem_stage (
    input  logic                            clk,
    input  logic                            rst_n,
    // ex/mem pipeline register
    input  logic                            ex_en,
    input  cpu_pkg::mem_op_e                ex_mem_op,
    input  logic [cpu_pkg::word_data_w-1:0] ex_alu_out,
    input  logic [cpu_pkg::word_data_w-1:0] ex_store_data,
    input  logic [cpu_pkg::reg_addr_w-1:0]  ex_dst_addr,
    input  logic                            ex_gpr_we,
    // pipeline control
    input  logic                            stall,
    input  logic                            flush,
    // mem/wb pipeline register
    output logic                            mem_en,
    output logic [cpu_pkg::reg_addr_w-1:0]  mem_dst_addr,
    output logic                            mem_gpr_we,
    output logic [cpu_pkg::word_data_w-1:0] mem_out,
    output logic                            out_rdy
);

    import cpu_pkg::*;

    // ram wires
    logic [dmem_addr_w-1:0] ram_addr;
    logic [word_data_w-1:0] ram_wdata;
    logic [word_data_w-1:0] ram_rdata;
    logic                   ram_we;

    // ctrl to register
    logic [word_data_w-1:0] mem_result;
    logic                   miss_align;
    logic                   load_rdy;

    mem_ctrl u_mem_ctrl (
        .ex_en         (ex_en),
        .ex_mem_op     (ex_mem_op),
        .ex_alu_out    (ex_alu_out),
        .ex_store_data (ex_store_data),
        .stall         (stall),          // write veto only
        .flush         (flush),
        .ram_rdata     (ram_rdata),
        .ram_addr      (ram_addr),
        .ram_wdata     (ram_wdata),
        .ram_we        (ram_we),
        .mem_result    (mem_result),
        .miss_align    (miss_align),
        .load_rdy      (load_rdy)
    );

    data_ram u_data_ram (
        .clk   (clk),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .we    (ram_we),
        .rdata (ram_rdata)
    );

    mem_reg u_mem_reg (
        .clk          (clk),
        .rst_n        (rst_n),
        .out          (mem_result),
        .miss_align   (miss_align),
        .stall        (stall),           // hold / clear decision
        .flush        (flush),
        .ex_en        (ex_en),
        .ex_dst_addr  (ex_dst_addr),
        .ex_gpr_we    (ex_gpr_we),
        .load_rdy     (load_rdy),
        .mem_en       (mem_en),
        .mem_dst_addr (mem_dst_addr),
        .mem_gpr_we   (mem_gpr_we),
        .out_rdy      (out_rdy),
        .mem_out      (mem_out)
    );

endmodule
